/* src/arc_board_pkg.sv */
package arc_board_pkg;

	// one RAM data word and its byte lanes
	typedef logic [31:0] word_t;
	typedef logic [3:0]  byte_sel_t;

	// one colour channel from the core
	typedef logic [3:0]  color_t;

	// base pixel clock request from the core
	typedef enum logic [1:0] {
		PIXCLK_24     = 2'b00,
		PIXCLK_25     = 2'b01,
		PIXCLK_36     = 2'b10,
		PIXCLK_24_ALT = 2'b11
	} pixclk_sel_t;

	// loader file index
	typedef logic [7:0]  loader_index_t;

	// rom image indexes that take over the RAM bus
	localparam loader_index_t LOADER_IDX_ROM_A = 8'd1;
	localparam loader_index_t LOADER_IDX_ROM_B = 8'd2;

	// the pixel PLL comes up in the 36 MHz setting
	localparam pixclk_sel_t PIXCLK_RESET_SEL = PIXCLK_36;

	// TV modes have both select bits equal
	function automatic logic is_tv_mode(input pixclk_sel_t sel);
		return sel[0] == sel[1];
	endfunction

	// true for the indexes that hold a rom image
	function automatic logic is_rom_index(input loader_index_t idx);
		return (idx == LOADER_IDX_ROM_A) || (idx == LOADER_IDX_ROM_B);
	endfunction

endpackage

/* src/boot_mem_mux.sv */
`timescale 1ns/1ps

module boot_mem_mux #(
	parameter int ADDR_W = 24
) (
	input  logic                           clk_sys,
	input  logic                           rst_n_i,

	// loader side
	input  logic                           dl_active_i,
	input  arc_board_pkg::loader_index_t   dl_index_i,
	input  logic                           loader_we_i,
	input  logic [ADDR_W-1:0]              loader_addr_i,
	input  arc_board_pkg::byte_sel_t       loader_sel_i,
	input  arc_board_pkg::word_t           loader_data_i,

	// core side
	input  logic                           core_stb_i,
	input  logic                           core_we_i,
	input  arc_board_pkg::byte_sel_t       core_sel_i,
	input  logic [ADDR_W-1:0]              core_addr_i,
	input  arc_board_pkg::word_t           core_data_i,
	output logic                           core_ack_o,

	// RAM controller side
	output logic                           ram_stb_o,
	output logic                           ram_cyc_o,
	output logic                           ram_we_o,
	output arc_board_pkg::byte_sel_t       ram_sel_o,
	output logic [ADDR_W-1:0]              ram_addr_o,
	output arc_board_pkg::word_t           ram_data_o,
	input  logic                           ram_ack_i,
	input  logic                           ram_ready_i,

	// boot reset
	input  logic                           button_reset_i,
	output logic                           core_reset_o
);

	import arc_board_pkg::*;

	logic loader_active;
	logic loader_active_q;
	logic loader_stb;
	logic rom_loaded;

	// only rom image downloads steer the bus
	assign loader_active = dl_active_i && is_rom_index(dl_index_i);

	// loader strobe held until the controller acknowledges
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			loader_stb <= 1'b0;
		end else if (loader_we_i) begin
			loader_stb <= 1'b1;
		end else if (ram_ack_i) begin
			loader_stb <= 1'b0;
		end
	end

	// end of a rom download marks the image as loaded
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			loader_active_q <= 1'b0;
			rom_loaded      <= 1'b0;
		end else begin
			loader_active_q <= loader_active;
			if (loader_active_q && !loader_active) begin
				rom_loaded <= 1'b1;
			end
		end
	end

	// core stays in reset until RAM and rom are both there
	assign core_reset_o = !ram_ready_i || !rom_loaded || button_reset_i;

	// bus owner select
	always_comb begin
		if (loader_active) begin
			ram_stb_o  = loader_stb;
			ram_cyc_o  = loader_stb;
			ram_we_o   = 1'b1;
			ram_sel_o  = loader_sel_i;
			ram_addr_o = {loader_addr_i[ADDR_W-1:2], 2'b00};
			ram_data_o = loader_data_i;
			// acks belong to the loader here
			core_ack_o = 1'b0;
		end else begin
			ram_stb_o  = core_stb_i;
			ram_cyc_o  = core_stb_i;
			ram_we_o   = core_we_i;
			ram_sel_o  = core_sel_i;
			ram_addr_o = {core_addr_i[ADDR_W-1:2], 2'b00};
			ram_data_o = core_data_i;
			core_ack_o = ram_ack_i;
		end
	end

endmodule

/* src/video_porch_blanker.sv */
`timescale 1ns/1ps

module video_porch_blanker #(
	parameter int PORCH_TV_BITS  = 8,
	parameter int PORCH_VGA_BITS = 6
) (
	input  logic                        clk_sys,
	input  logic                        rst_n_i,
	input  logic                        ce_pix_i,
	input  arc_board_pkg::pixclk_sel_t  pixclk_sel_i,

	// raw core video
	input  arc_board_pkg::color_t       core_r_i,
	input  arc_board_pkg::color_t       core_g_i,
	input  arc_board_pkg::color_t       core_b_i,
	input  logic                        core_hs_i,
	input  logic                        core_vs_i,

	// blanked video
	output arc_board_pkg::color_t       vid_r_o,
	output arc_board_pkg::color_t       vid_g_o,
	output arc_board_pkg::color_t       vid_b_o,
	output logic                        vid_hs_o,
	output logic                        vid_vs_o
);

	import arc_board_pkg::*;

	// counter is as wide as the larger window
	localparam int CNT_W = (PORCH_TV_BITS > PORCH_VGA_BITS) ? PORCH_TV_BITS : PORCH_VGA_BITS;

	logic [CNT_W-1:0] porch_cnt;
	logic             porch_done;

	// window saturated after 256 cycles in TV modes and 64 otherwise by default
	assign porch_done = is_tv_mode(pixclk_sel_i) ? &porch_cnt[PORCH_TV_BITS-1:0]
	                                             : &porch_cnt[PORCH_VGA_BITS-1:0];

	// restarts on every low phase of the registered hsync
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			porch_cnt <= '0;
		end else if (!vid_hs_o) begin
			porch_cnt <= '0;
		end else if (!porch_done) begin
			porch_cnt <= porch_cnt + CNT_W'(1);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			vid_hs_o <= 1'b0;
			vid_vs_o <= 1'b0;
			vid_r_o  <= '0;
			vid_g_o  <= '0;
			vid_b_o  <= '0;
		end else if (ce_pix_i) begin
			vid_hs_o <= core_hs_i;
			vid_vs_o <= core_vs_i;
			if (porch_done) begin
				vid_r_o <= core_r_i;
				vid_g_o <= core_g_i;
				vid_b_o <= core_b_i;
			end else begin
				// black through the back porch
				vid_r_o <= '0;
				vid_g_o <= '0;
				vid_b_o <= '0;
			end
		end
	end

endmodule

/* src/pixclk_reconfig_seq.sv */
`timescale 1ns/1ps

module pixclk_reconfig_seq #(
	parameter int RECONFIG_TIMEOUT = 1000
) (
	input  logic                        clk_sys,
	input  logic                        rst_n_i,
	input  arc_board_pkg::pixclk_sel_t  pixclk_sel_i,

	// reconfiguration block handshake
	input  logic                        rcfg_busy_i,
	output logic                        rcfg_write_rom_o,
	output logic                        rcfg_start_o,
	output logic                        rcfg_reset_o,

	// configuration rom bits
	input  logic                        rom_q_24_i,
	input  logic                        rom_q_25_i,
	input  logic                        rom_q_36_i,
	output logic                        rom_q_o
);

	import arc_board_pkg::*;

	localparam int TMO_W = $clog2(RECONFIG_TIMEOUT + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_WAIT_NB,
		ST_RUN
	} state_t;

	state_t            state;
	pixclk_sel_t       sel_q;
	logic [TMO_W-1:0]  tmo_cnt;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			state            <= ST_IDLE;
			sel_q            <= PIXCLK_RESET_SEL;
			tmo_cnt          <= '0;
			rcfg_write_rom_o <= 1'b0;
			rcfg_start_o     <= 1'b0;
			rcfg_reset_o     <= 1'b0;
		end else begin
			// all three handshake outputs are single cycle pulses
			rcfg_write_rom_o <= 1'b0;
			rcfg_start_o     <= 1'b0;
			rcfg_reset_o     <= 1'b0;
			case (state)
				ST_IDLE: begin
					sel_q <= pixclk_sel_i;
					if (sel_q != pixclk_sel_i) begin
						rcfg_write_rom_o <= 1'b1;
						state            <= ST_LOAD;
					end
				end
				// one cycle for the rom write request to be taken
				ST_LOAD: begin
					state <= ST_WAIT_NB;
				end
				ST_WAIT_NB: begin
					if (!rcfg_busy_i) begin
						rcfg_start_o <= 1'b1;
						tmo_cnt      <= TMO_W'(RECONFIG_TIMEOUT);
						state        <= ST_RUN;
					end
				end
				ST_RUN: begin
					tmo_cnt <= tmo_cnt - TMO_W'(1);
					// block stuck busy so kick it
					if (tmo_cnt == TMO_W'(1)) begin
						rcfg_reset_o <= 1'b1;
						state        <= ST_IDLE;
					end
					if (!rcfg_start_o && !rcfg_busy_i) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// rom bit for the requested clock
	always_comb begin
		case (pixclk_sel_i)
			PIXCLK_25: rom_q_o = rom_q_25_i;
			PIXCLK_36: rom_q_o = rom_q_36_i;
			default:   rom_q_o = rom_q_24_i;
		endcase
	end

endmodule

/* src/arc_board_top.sv */
`timescale 1ns/1ps

module arc_board_top #(
	parameter int ADDR_W           = 24,
	parameter int RECONFIG_TIMEOUT = 1000,
	parameter int PORCH_TV_BITS    = 8,
	parameter int PORCH_VGA_BITS   = 6
) (
	input  logic                           clk_sys,
	input  logic                           rst_n_i,
	input  arc_board_pkg::pixclk_sel_t     pixclk_sel_i,

	// loader
	input  logic                           dl_active_i,
	input  arc_board_pkg::loader_index_t   dl_index_i,
	input  logic                           loader_we_i,
	input  logic [ADDR_W-1:0]              loader_addr_i,
	input  arc_board_pkg::byte_sel_t       loader_sel_i,
	input  arc_board_pkg::word_t           loader_data_i,

	// core memory bus
	input  logic                           core_stb_i,
	input  logic                           core_we_i,
	input  arc_board_pkg::byte_sel_t       core_sel_i,
	input  logic [ADDR_W-1:0]              core_addr_i,
	input  arc_board_pkg::word_t           core_data_i,
	output logic                           core_ack_o,

	// RAM controller
	output logic                           ram_stb_o,
	output logic                           ram_cyc_o,
	output logic                           ram_we_o,
	output arc_board_pkg::byte_sel_t       ram_sel_o,
	output logic [ADDR_W-1:0]              ram_addr_o,
	output arc_board_pkg::word_t           ram_data_o,
	input  logic                           ram_ack_i,
	input  logic                           ram_ready_i,

	// boot reset
	input  logic                           button_reset_i,
	output logic                           core_reset_o,

	// video
	input  logic                           ce_pix_i,
	input  arc_board_pkg::color_t          core_r_i,
	input  arc_board_pkg::color_t          core_g_i,
	input  arc_board_pkg::color_t          core_b_i,
	input  logic                           core_hs_i,
	input  logic                           core_vs_i,
	output arc_board_pkg::color_t          vid_r_o,
	output arc_board_pkg::color_t          vid_g_o,
	output arc_board_pkg::color_t          vid_b_o,
	output logic                           vid_hs_o,
	output logic                           vid_vs_o,

	// pixel PLL reconfiguration
	input  logic                           rcfg_busy_i,
	output logic                           rcfg_write_rom_o,
	output logic                           rcfg_start_o,
	output logic                           rcfg_reset_o,
	input  logic                           rom_q_24_i,
	input  logic                           rom_q_25_i,
	input  logic                           rom_q_36_i,
	output logic                           rom_q_o
);

	boot_mem_mux #(
		.ADDR_W         (ADDR_W)
	) u_boot_mem_mux (
		.clk_sys        (clk_sys),
		.rst_n_i        (rst_n_i),
		.dl_active_i    (dl_active_i),
		.dl_index_i     (dl_index_i),
		.loader_we_i    (loader_we_i),
		.loader_addr_i  (loader_addr_i),
		.loader_sel_i   (loader_sel_i),
		.loader_data_i  (loader_data_i),
		.core_stb_i     (core_stb_i),
		.core_we_i      (core_we_i),
		.core_sel_i     (core_sel_i),
		.core_addr_i    (core_addr_i),
		.core_data_i    (core_data_i),
		.core_ack_o     (core_ack_o),
		.ram_stb_o      (ram_stb_o),
		.ram_cyc_o      (ram_cyc_o),
		.ram_we_o       (ram_we_o),
		.ram_sel_o      (ram_sel_o),
		.ram_addr_o     (ram_addr_o),
		.ram_data_o     (ram_data_o),
		.ram_ack_i      (ram_ack_i),
		.ram_ready_i    (ram_ready_i),
		.button_reset_i (button_reset_i),
		.core_reset_o   (core_reset_o)
	);

	video_porch_blanker #(
		.PORCH_TV_BITS  (PORCH_TV_BITS),
		.PORCH_VGA_BITS (PORCH_VGA_BITS)
	) u_video_porch_blanker (
		.clk_sys        (clk_sys),
		.rst_n_i        (rst_n_i),
		.ce_pix_i       (ce_pix_i),
		.pixclk_sel_i   (pixclk_sel_i),
		.core_r_i       (core_r_i),
		.core_g_i       (core_g_i),
		.core_b_i       (core_b_i),
		.core_hs_i      (core_hs_i),
		.core_vs_i      (core_vs_i),
		.vid_r_o        (vid_r_o),
		.vid_g_o        (vid_g_o),
		.vid_b_o        (vid_b_o),
		.vid_hs_o       (vid_hs_o),
		.vid_vs_o       (vid_vs_o)
	);

	pixclk_reconfig_seq #(
		.RECONFIG_TIMEOUT (RECONFIG_TIMEOUT)
	) u_pixclk_reconfig_seq (
		.clk_sys          (clk_sys),
		.rst_n_i          (rst_n_i),
		.pixclk_sel_i     (pixclk_sel_i),
		.rcfg_busy_i      (rcfg_busy_i),
		.rcfg_write_rom_o (rcfg_write_rom_o),
		.rcfg_start_o     (rcfg_start_o),
		.rcfg_reset_o     (rcfg_reset_o),
		.rom_q_24_i       (rom_q_24_i),
		.rom_q_25_i       (rom_q_25_i),
		.rom_q_36_i       (rom_q_36_i),
		.rom_q_o          (rom_q_o)
	);

endmodule

/* testbench/tb_arc_board.sv */
`timescale 1ns/1ps

module tb_arc_board;

	import arc_board_pkg::*;

	localparam int ADDR_W           = 24;
	localparam int RECONFIG_TIMEOUT = 64;
	localparam int PORCH_TV_BITS    = 8;
	localparam int PORCH_VGA_BITS   = 6;
	localparam int CLK_PERIOD       = 8;
	localparam int CORE_XFERS       = 40;
	localparam int LOAD_XFERS       = 24;
	localparam int XFER_CYCLES      = 9;
	localparam int ACK_LIMIT        = 16;
	localparam int WATCH_CYCLES     = 30;
	localparam int MODE_STEPS       = 5;
	// mode order from the low bits up is 36 then 24 then 24 alt then 25 then 36
	localparam logic [9:0] MODE_SEQ = {2'b10, 2'b01, 2'b11, 2'b00, 2'b10};
	localparam int TEST_CYCLES = 40 + (CORE_XFERS + LOAD_XFERS) * XFER_CYCLES
		+ 2 * 34 + (1 << PORCH_TV_BITS) + (1 << PORCH_VGA_BITS)
		+ MODE_STEPS * WATCH_CYCLES + RECONFIG_TIMEOUT + WATCH_CYCLES + 12;
	localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD * 6 / 5;

	logic clk_sys, rst_n_i;
	pixclk_sel_t pixclk_sel_i;
	logic dl_active_i;
	loader_index_t dl_index_i;
	logic loader_we_i;
	logic [ADDR_W-1:0] loader_addr_i, core_addr_i, ram_addr_o;
	byte_sel_t loader_sel_i, core_sel_i, ram_sel_o;
	word_t loader_data_i, core_data_i, ram_data_o;
	logic core_stb_i, core_we_i, core_ack_o;
	logic ram_stb_o, ram_cyc_o, ram_we_o, ram_ack_i, ram_ready_i;
	logic button_reset_i, core_reset_o, ce_pix_i;
	color_t core_r_i, core_g_i, core_b_i, vid_r_o, vid_g_o, vid_b_o;
	logic core_hs_i, core_vs_i, vid_hs_o, vid_vs_o;
	logic rcfg_busy_i, rcfg_write_rom_o, rcfg_start_o, rcfg_reset_o;
	logic rom_q_24_i, rom_q_25_i, rom_q_36_i, rom_q_o;

	int errors = 0;
	int checks = 0;
	integer seed = 53155;
	logic busy_stuck = 1'b0;

	arc_board_top #(
		.ADDR_W           (ADDR_W),
		.RECONFIG_TIMEOUT (RECONFIG_TIMEOUT),
		.PORCH_TV_BITS    (PORCH_TV_BITS),
		.PORCH_VGA_BITS   (PORCH_VGA_BITS)
	) DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// loader owns the bus only for rom image indexes 1 and 2
	function automatic logic loader_owns_bus(input logic active, input logic [7:0] idx);
		return active && (idx == 8'd1 || idx == 8'd2);
	endfunction

	function automatic logic [ADDR_W-1:0] word_addr(input logic [ADDR_W-1:0] a);
		return {a[ADDR_W-1:2], 2'b00};
	endfunction

	function automatic logic exp_core_reset(input logic ready, input logic loaded, input logic btn);
		return !ready || !loaded || btn;
	endfunction

	// TV modes have equal select bits and the wider window
	function automatic int window_len(input logic [1:0] sel);
		return (sel[0] == sel[1]) ? (1 << PORCH_TV_BITS) : (1 << PORCH_VGA_BITS);
	endfunction

	function automatic logic exp_rom_bit(input logic [1:0] sel, input logic q24,
			input logic q25, input logic q36);
		case (sel)
			2'b01:   return q25;
			2'b10:   return q36;
			default: return q24;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("%s at %0t", msg, $time);
	endtask

	task automatic check_ram_bus(input logic loader_stb_exp);
		logic owns;
		logic exp_stb;
		owns = loader_owns_bus(dl_active_i, dl_index_i);
		exp_stb = owns ? loader_stb_exp : core_stb_i;
		check_value("ram_stb_o", 64'(ram_stb_o), 64'(exp_stb));
		check_value("ram_cyc_o", 64'(ram_cyc_o), 64'(exp_stb));
		check_value("ram_we_o", 64'(ram_we_o), 64'(owns ? 1'b1 : core_we_i));
		check_value("ram_sel_o", 64'(ram_sel_o), 64'(owns ? loader_sel_i : core_sel_i));
		check_value("ram_addr_o", 64'(ram_addr_o),
			64'(word_addr(owns ? loader_addr_i : core_addr_i)));
		check_value("ram_data_o", 64'(ram_data_o), 64'(owns ? loader_data_i : core_data_i));
		check_value("core_ack_o", 64'(core_ack_o), 64'(owns ? 1'b0 : ram_ack_i));
	endtask

	// acknowledge each strobe after 1 to 4 cycles
	initial begin : ram_model
		int delay;
		ram_ack_i = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (ram_stb_o === 1'b1) begin
				delay = 1 + ($unsigned($random(seed)) % 4);
				repeat (delay) @(posedge clk_sys);
				#1 ram_ack_i = 1'b1;
				@(posedge clk_sys);
				#1 ram_ack_i = 1'b0;
			end
		end
	end

	// busy for 1 to 8 cycles after a start and longer while stuck
	initial begin : rcfg_model
		int busy_len;
		rcfg_busy_i = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (rcfg_start_o === 1'b1) begin
				busy_len = 1 + ($unsigned($random(seed)) % 8);
				@(posedge clk_sys);
				#1 rcfg_busy_i = 1'b1;
				repeat (busy_len) @(posedge clk_sys);
				while (busy_stuck) @(posedge clk_sys);
				#1 rcfg_busy_i = 1'b0;
			end
		end
	end

	// tasks below start and end 1 ns after a rising edge
	task automatic core_transfer();
		int waited;
		core_stb_i = 1'b1;
		core_we_i = 1'($random(seed));
		core_sel_i = 4'($random(seed));
		core_addr_i = ADDR_W'($random(seed));
		core_data_i = 32'($random(seed));
		waited = 0;
		do begin
			@(negedge clk_sys);
			check_ram_bus(1'b0);
			waited++;
		end while (ram_ack_i !== 1'b1 && waited < ACK_LIMIT);
		if (ram_ack_i !== 1'b1)
			note_failure("RAM never acknowledged a core transfer");
		@(posedge clk_sys);
		#1 core_stb_i = 1'b0;
		@(negedge clk_sys);
		check_ram_bus(1'b0);
		@(posedge clk_sys);
		#1;
	endtask

	task automatic loader_write();
		int waited;
		loader_addr_i = ADDR_W'($random(seed));
		loader_sel_i = 4'($random(seed));
		loader_data_i = 32'($random(seed));
		loader_we_i = 1'b1;
		@(negedge clk_sys);
		check_ram_bus(1'b0);
		@(posedge clk_sys);
		#1 loader_we_i = 1'b0;
		waited = 0;
		do begin
			@(negedge clk_sys);
			check_ram_bus(1'b1);
			waited++;
		end while (ram_ack_i !== 1'b1 && waited < ACK_LIMIT);
		if (ram_ack_i !== 1'b1)
			note_failure("RAM never acknowledged a loader write");
		@(posedge clk_sys);
		#1;
		// strobe drops after the acknowledge
		@(negedge clk_sys);
		check_ram_bus(1'b0);
		@(posedge clk_sys);
		#1;
	endtask

	task automatic porch_test(input pixclk_sel_t mode);
		int len;
		int n;
		int i;
		logic [11:0] prev_rgb;
		logic prev_hs;
		logic prev_vs;
		len = window_len(mode);
		pixclk_sel_i = mode;
		ce_pix_i = 1'b1;
		for (i = 0; i < len + 34; i++) begin
			prev_rgb = {core_r_i, core_g_i, core_b_i};
			prev_hs = core_hs_i;
			prev_vs = core_vs_i;
			// ten cycles of sync low before the back porch starts
			core_hs_i = (i >= 10);
			core_vs_i = 1'($random(seed));
			{core_r_i, core_g_i, core_b_i} = 12'($random(seed));
			@(negedge clk_sys);
			check_value("vid_hs_o", 64'(vid_hs_o), 64'(prev_hs));
			check_value("vid_vs_o", 64'(vid_vs_o), 64'(prev_vs));
			n = i - 11;
			if (n >= 0 && n < len - 2)
				check_value("vid_rgb", 64'({vid_r_o, vid_g_o, vid_b_o}), 64'(0));
			else if (n >= len + 3)
				check_value("vid_rgb", 64'({vid_r_o, vid_g_o, vid_b_o}), 64'(prev_rgb));
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic watch_rcfg(input int cycles, output int n_wr, output int n_st,
			output int n_rst, output int t_st, output int t_rst);
		int c;
		logic last_busy;
		n_wr = 0;
		n_st = 0;
		n_rst = 0;
		t_st = -1;
		t_rst = -1;
		last_busy = rcfg_busy_i;
		for (c = 0; c < cycles; c++) begin
			{rom_q_24_i, rom_q_25_i, rom_q_36_i} = 3'($random(seed));
			@(negedge clk_sys);
			check_value("rom_q_o", 64'(rom_q_o),
				64'(exp_rom_bit(pixclk_sel_i, rom_q_24_i, rom_q_25_i, rom_q_36_i)));
			if (rcfg_write_rom_o === 1'b1)
				n_wr++;
			if (rcfg_start_o === 1'b1) begin
				n_st++;
				t_st = c;
				if (n_wr == 0)
					note_failure("rcfg start pulse came before any ROM write");
				check_value("rcfg_busy_i before start", 64'(last_busy), 64'(0));
			end
			if (rcfg_reset_o === 1'b1) begin
				n_rst++;
				t_rst = c;
			end
			last_busy = rcfg_busy_i;
			@(posedge clk_sys);
			#1;
		end
	endtask

	initial begin : stimulus
		int i;
		int k;
		int n_wr, n_st, n_rst, t_st, t_rst;
		rst_n_i = 1'b0;
		pixclk_sel_i = PIXCLK_36;
		{dl_active_i, dl_index_i, loader_we_i} = '0;
		{loader_addr_i, loader_sel_i, loader_data_i} = '0;
		{core_stb_i, core_we_i, core_sel_i, core_addr_i, core_data_i} = '0;
		{ram_ready_i, button_reset_i, ce_pix_i} = '0;
		{core_r_i, core_g_i, core_b_i, core_hs_i, core_vs_i} = '0;
		{rom_q_24_i, rom_q_25_i, rom_q_36_i} = '0;
		repeat (5) @(posedge clk_sys);
		#1 rst_n_i = 1'b1;
		@(negedge clk_sys);
		check_value("ram_stb_o", 64'(ram_stb_o), 64'(0));
		check_value("core_reset_o", 64'(core_reset_o), 64'(1));
		check_value("vid_out", 64'({vid_r_o, vid_g_o, vid_b_o, vid_hs_o, vid_vs_o}), 64'(0));
		check_value("rcfg_out", 64'({rcfg_write_rom_o, rcfg_start_o, rcfg_reset_o}), 64'(0));
		@(posedge clk_sys);
		#1;

		// core passthrough with the second half downloading on index 3
		for (i = 0; i < CORE_XFERS; i++) begin
			if (i == CORE_XFERS / 2) begin
				dl_active_i = 1'b1;
				dl_index_i = 8'd3;
			end
			core_transfer();
		end
		check_value("core_reset_o", 64'(core_reset_o), 64'(exp_core_reset(1'b0, 1'b0, 1'b0)));

		// rom download with the RAM already ready
		ram_ready_i = 1'b1;
		for (i = 0; i < LOAD_XFERS; i++) begin
			dl_index_i = (i < LOAD_XFERS / 2) ? LOADER_IDX_ROM_A : LOADER_IDX_ROM_B;
			loader_write();
		end
		@(negedge clk_sys);
		check_value("core_reset_o", 64'(core_reset_o), 64'(exp_core_reset(1'b1, 1'b0, 1'b0)));
		@(posedge clk_sys);
		#1 dl_active_i = 1'b0;
		k = 0;
		do begin
			@(negedge clk_sys);
			k++;
		end while (core_reset_o !== 1'b0 && k < 2);
		check_value("core_reset_o", 64'(core_reset_o), 64'(exp_core_reset(1'b1, 1'b1, 1'b0)));
		// every mix of RAM ready and button once the rom is loaded
		for (k = 0; k < 8; k++) begin
			@(posedge clk_sys);
			#1 {ram_ready_i, button_reset_i} = 2'(k);
			@(negedge clk_sys);
			check_value("core_reset_o", 64'(core_reset_o),
				64'(exp_core_reset(ram_ready_i, 1'b1, button_reset_i)));
		end
		@(posedge clk_sys);
		#1 button_reset_i = 1'b0;
		ram_ready_i = 1'b1;

		porch_test(PIXCLK_24);
		porch_test(PIXCLK_25);

		for (i = 0; i < MODE_STEPS; i++) begin
			pixclk_sel_i = pixclk_sel_t'(MODE_SEQ[2*i +: 2]);
			watch_rcfg(WATCH_CYCLES, n_wr, n_st, n_rst, t_st, t_rst);
			check_value("rcfg_write_rom_o pulses", 64'(n_wr), 64'(1));
			check_value("rcfg_start_o pulses", 64'(n_st), 64'(1));
			check_value("rcfg_reset_o pulses", 64'(n_rst), 64'(0));
		end

		// reconfiguration block hangs in busy
		busy_stuck = 1'b1;
		pixclk_sel_i = PIXCLK_24;
		watch_rcfg(RECONFIG_TIMEOUT + WATCH_CYCLES, n_wr, n_st, n_rst, t_st, t_rst);
		check_value("rcfg_write_rom_o pulses", 64'(n_wr), 64'(1));
		check_value("rcfg_start_o pulses", 64'(n_st), 64'(1));
		check_value("rcfg_reset_o pulses", 64'(n_rst), 64'(1));
		if (n_rst == 1 && t_rst - t_st < RECONFIG_TIMEOUT - 2)
			note_failure("rcfg_reset_o pulsed too soon after the start pulse");
		busy_stuck = 1'b0;
		repeat (12) @(posedge clk_sys);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog expired, the tests did not finish in time");
		$display("Verification failed");
		$finish;
	end

endmodule

/* filelist.f */
src/arc_board_pkg.sv
src/boot_mem_mux.sv
src/video_porch_blanker.sv
src/pixclk_reconfig_seq.sv
src/arc_board_top.sv
testbench/tb_arc_board.sv

/* run_sim.sh */
#!/bin/sh
# build and run the board glue testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module tb_arc_board -o sim_arc_board

./obj_dir/sim_arc_board > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

if ! grep -q "Verification passed" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0
